/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
LINTFLAGS = --lint-only --timing
TOP       = tb_step_motor
RTL_TOP   = step_motor
FILELIST  = build.f
PASS_MSG  = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

/* build.f */
+incdir+include
hdl/ramp_pkg.sv
hdl/motor_pkg.sv
hdl/speed_table.sv
hdl/zero_point_detect.sv
hdl/motor_channel.sv
hdl/step_motor.sv
test/tb_step_motor.sv

/* hdl/motor_channel.sv */
`timescale 1ns/1ps

module motor_channel (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    tick,
	input  motor_pkg::motor_cmd_t   cmd,
	input  motor_pkg::step_cnt_t    stroke,
	input  logic                    busy_load,
	input  ramp_pkg::ramp_idx_t     ramp_len,
	output ramp_pkg::ramp_idx_t     rd_idx,
	input  ramp_pkg::speed_t        rd_delay,
	input  logic                    zero_hit,
	output motor_pkg::motor_status_t status,
	output motor_pkg::motor_drive_t  drv
);
	import ramp_pkg::*;
	import motor_pkg::*;

	logic      run;
	logic      dir_q;
	ramp_idx_t speed_q;
	ms_t       ms_q;
	step_cnt_t remain;
	step_cnt_t position;
	ramp_idx_t idx;
	speed_t    dly_cnt;
	logic      stop_q;
	logic      drive_q;
	logic      zpsign_q;
	logic      tpsign_q;
	logic      xen_q;
	logic      xrst_q;

	logic                       accept;
	logic                       stop_now;
	logic                       at_stroke;
	logic                       homed;
	logic                       move_end;
	logic                       dly_done;
	logic                       fire;
	step_cnt_t                  left;
	step_cnt_t                  idx_ext;
	logic [$bits(ramp_idx_t):0] idx_inc;
	logic                       ramp_up;
	logic                       ramp_down;

	assign accept    = cmd.start && !run && !busy_load;
	assign stop_now  = stop_q || cmd.stop; // Same-cycle stop blocks the pulse
	assign at_stroke = dir_q && position >= stroke;
	assign homed     = !dir_q && zero_hit;
	assign move_end  = stop_now || at_stroke || homed || remain == '0;
	assign dly_done  = dly_cnt + 1'b1 >= rd_delay;
	assign fire      = run && tick && !move_end && dly_done;

	// Steps still to go once this pulse is out
	assign left    = remain - 1'b1;
	assign idx_ext = step_cnt_t'(idx);
	assign idx_inc = {1'b0, idx} + 1'b1;

	// Climb while the braking distance still fits, mirror it on the way down
	assign ramp_up   = idx < speed_q && idx_inc < {1'b0, ramp_len} && left > idx_ext + 1'b1;
	assign ramp_down = left <= idx_ext && idx != '0;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			run      <= 1'b0;
			dir_q    <= 1'b0;
			ms_q     <= '0;
			idx      <= '0;
			position <= '0;
			stop_q   <= 1'b0;
			drive_q  <= 1'b0;
			zpsign_q <= 1'b0;
			tpsign_q <= 1'b0;
			xen_q    <= 1'b1;
			xrst_q   <= 1'b0;
		end else begin
			xen_q    <= cmd.xen;
			xrst_q   <= cmd.xrst;
			drive_q  <= fire;
			tpsign_q <= position == stroke;
			if (accept) begin
				run     <= 1'b1;
				dir_q   <= cmd.dir;
				speed_q <= cmd.speed;
				ms_q    <= cmd.ms;
				remain  <= cmd.step;
				idx     <= '0;
				dly_cnt <= '0;
				stop_q  <= 1'b0;
			end else if (run) begin
				if (cmd.stop)
					stop_q <= 1'b1;
				if (tick) begin
					if (move_end) begin
						run <= 1'b0;
						idx <= '0; // Next move reads entry 0 early
						if (homed) begin
							position <= '0;
							zpsign_q <= 1'b1;
						end
					end else if (dly_done) begin
						dly_cnt  <= '0;
						remain   <= left;
						position <= dir_q ? position + 1'b1 : position - 1'b1;
						zpsign_q <= 1'b0;
						if (ramp_up)
							idx <= idx + 1'b1;
						else if (ramp_down)
							idx <= idx - 1'b1;
					end else begin
						dly_cnt <= dly_cnt + 1'b1;
					end
				end
			end
		end
	end

	assign rd_idx = idx;

	assign status.state  = run;
	assign status.zpsign = zpsign_q;
	assign status.tpsign = tpsign_q;

	assign drv.drive = drive_q;
	assign drv.dir   = dir_q;
	assign drv.ms    = ms_q;
	assign drv.xen   = xen_q;
	assign drv.xrst  = xrst_q;

	a_drive_in_move: assert property (@(posedge clk) disable iff (!resetn)
		drv.drive |-> status.state)
		else $error("motor_channel: step pulse outside a move");

	a_idx_in_table: assert property (@(posedge clk) disable iff (!resetn)
		run |-> idx < ramp_len)
		else $error("motor_channel: ramp index past loaded table");

endmodule

/* hdl/motor_pkg.sv */
`include "step_defs.svh"

package motor_pkg;

	typedef logic [`STEP_NUMBER_WIDTH-1:0] step_cnt_t;

	typedef logic [`MICROSTEP_WIDTH-1:0] ms_t;

	// Move command of one axis
	typedef struct packed {
		logic                start; // One-cycle pulse
		logic                stop;
		logic                dir;   // 1 counts position up
		ramp_pkg::ramp_idx_t speed; // Top ramp level
		step_cnt_t           step;
		ms_t                 ms;
		logic                xen;
		logic                xrst;
	} motor_cmd_t;

	typedef struct packed {
		logic state;  // Move in progress
		logic zpsign; // Homed and still at 0
		logic tpsign; // At the stroke limit
	} motor_status_t;

	// Pins of the stepper driver
	typedef struct packed {
		logic drive; // One clk per step
		logic dir;
		ms_t  ms;
		logic xen;
		logic xrst;
	} motor_drive_t;

endpackage

/* hdl/ramp_pkg.sv */
`include "step_defs.svh"

package ramp_pkg;

	typedef logic [`SPEED_DATA_WIDTH-1:0] speed_t; // Ticks between two steps

	typedef logic [`SPEED_ADDRESS_WIDTH-1:0] ramp_idx_t;

	// Load strobe group of the speed table
	typedef struct packed {
		logic   init;  // High for the whole load
		logic   wr_en; // One word per cycle
		speed_t data;
	} ramp_wr_t;

endpackage

/* hdl/speed_table.sv */
`timescale 1ns/1ps
`include "step_defs.svh"

module speed_table (
	input  logic                clk,
	input  logic                resetn,
	input  ramp_pkg::ramp_wr_t  wr,
	input  ramp_pkg::ramp_idx_t rd_idx [`MOTOR_NBR],
	output ramp_pkg::speed_t    rd_delay [`MOTOR_NBR],
	output ramp_pkg::ramp_idx_t ramp_len
);
	import ramp_pkg::*;

	localparam int DEPTH = 1 << `SPEED_ADDRESS_WIDTH;

	speed_t    mem [DEPTH];
	ramp_idx_t wr_ptr;
	ramp_idx_t wr_addr;
	logic      init_d;
	logic      full;
	logic      load_start;
	logic      wr_ok;

	assign load_start = wr.init && !init_d; // Rising init restarts the load
	assign wr_addr    = load_start ? '0 : wr_ptr;
	assign wr_ok      = wr.init && wr.wr_en && (load_start || !full);
	assign ramp_len   = wr_ptr; // Saturates on the last address

	always_ff @(posedge clk) begin
		if (!resetn) begin
			init_d <= 1'b0;
			wr_ptr <= '0;
			full   <= 1'b0;
		end else begin
			init_d <= wr.init;
			if (load_start) begin
				wr_ptr <= '0;
				full   <= 1'b0;
			end
			if (wr_ok) begin
				if (wr_addr == ramp_idx_t'(DEPTH - 1))
					full <= 1'b1;
				else
					wr_ptr <= wr_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ok)
			mem[wr_addr] <= wr.data;
	end

	// One registered read port per motor
	always_ff @(posedge clk) begin
		for (int i = 0; i < `MOTOR_NBR; i++)
			rd_delay[i] <= mem[rd_idx[i]];
	end

	a_no_write_when_full: assert property (@(posedge clk) disable iff (!resetn)
		wr.init && wr.wr_en && !load_start |-> !full)
		else $error("speed_table: load word dropped, table is full");

endmodule

/* hdl/step_motor.sv */
`timescale 1ns/1ps
`include "step_defs.svh"

module step_motor (
	input  logic                     clk,
	input  logic                     resetn,
	input  ramp_pkg::ramp_wr_t       br,
	input  logic [`MOTOR_NBR-1:0]    zpd,
	input  motor_pkg::step_cnt_t     stroke [`MOTOR_NBR],
	input  motor_pkg::motor_cmd_t    cmd [`MOTOR_NBR],
	output motor_pkg::motor_status_t status [`MOTOR_NBR],
	output motor_pkg::motor_drive_t  drv [`MOTOR_NBR]
);
	import ramp_pkg::*;

	localparam int DIV_W = $clog2(`CLK_DIV_NBR + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`CLK_DIV_NBR - 1);

	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	ramp_idx_t        rd_idx [`MOTOR_NBR];
	speed_t           rd_delay [`MOTOR_NBR];
	ramp_idx_t        ramp_len;

	// Shared motion time base
	assign tick = div_cnt == DIV_LAST;

	always_ff @(posedge clk) begin
		if (!resetn)
			div_cnt <= '0;
		else if (tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	speed_table table_i (
		.clk     (clk),
		.resetn  (resetn),
		.wr      (br),
		.rd_idx  (rd_idx),
		.rd_delay(rd_delay),
		.ramp_len(ramp_len)
	);

	genvar m;
	generate
		for (m = 0; m < `MOTOR_NBR; m++) begin : g_motor
			logic zero_hit;

			zero_point_detect zpd_i (
				.clk     (clk),
				.resetn  (resetn),
				.tick    (tick),
				.zpd     (zpd[m]),
				.zero_hit(zero_hit)
			);

			motor_channel ch_i (
				.clk      (clk),
				.resetn   (resetn),
				.tick     (tick),
				.cmd      (cmd[m]),
				.stroke   (stroke[m]),
				.busy_load(br.init),
				.ramp_len (ramp_len),
				.rd_idx   (rd_idx[m]),
				.rd_delay (rd_delay[m]),
				.zero_hit (zero_hit),
				.status   (status[m]),
				.drv      (drv[m])
			);
		end
	endgenerate

endmodule

/* hdl/zero_point_detect.sv */
`timescale 1ns/1ps
`include "step_defs.svh"

module zero_point_detect (
	input  logic clk,
	input  logic resetn,
	input  logic tick,
	input  logic zpd,
	output logic zero_hit
);

	logic [`ZPD_SEQ_LEN-1:0] hist;
	logic [`ZPD_SEQ_LEN-1:0] hist_next;

	// Newest sample enters at bit 0
	always_comb begin
		hist_next    = hist << 1;
		hist_next[0] = zpd;
	end

	// Fires on the tick whose sample completes the pattern
	assign zero_hit = tick && (hist_next == `ZPD_SEQ);

	always_ff @(posedge clk) begin
		if (!resetn)
			hist <= '1; // An axis parked on the sensor does not fire
		else if (tick)
			hist <= hist_next;
	end

endmodule

/* include/step_defs.svh */
`ifndef STEP_DEFS_SVH
`define STEP_DEFS_SVH

// Step count, position and stroke
`define STEP_NUMBER_WIDTH 16

// One delay word of the speed table, in ticks
`define SPEED_DATA_WIDTH 16

// Table address, 512 words deep
`define SPEED_ADDRESS_WIDTH 9

`define MICROSTEP_WIDTH 3

// clk cycles per motion tick
`define CLK_DIV_NBR 5

`define MOTOR_NBR 2

// Home pattern, oldest sample in the MSB
`define ZPD_SEQ_LEN 2
`define ZPD_SEQ 2'b01

`endif

/* test/tb_step_motor.sv */
`timescale 1ns/1ps
`include "step_defs.svh"

module tb_step_motor;
	import ramp_pkg::*;
	import motor_pkg::*;

	localparam int DIV = `CLK_DIV_NBR;
	localparam int NM  = `MOTOR_NBR;

	logic           clk;
	logic           resetn;
	ramp_wr_t       br;
	logic [NM-1:0]  zpd = '1;
	step_cnt_t      stroke [NM];
	motor_cmd_t     cmd [NM];
	motor_status_t  status [NM];
	motor_drive_t   drv [NM];

	int       errors = 0;
	int       timeouts = 0;
	int       cyc = 0;
	int       pulse_cnt [NM];
	int       model_pos [NM] = '{default: 0};
	int       sensor_pt [NM] = '{default: 0};
	speed_t   tbl [$];
	int       iv [$];
	logic     rec = 1'b0;
	logic     have_last = 1'b0;
	int       last_cyc;

	step_motor dut_i (
		.clk   (clk),
		.resetn(resetn),
		.br    (br),
		.zpd   (zpd),
		.stroke(stroke),
		.cmd   (cmd),
		.status(status),
		.drv   (drv)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) cyc++;

	// Pulse counter and position model, sampled mid-cycle
	always @(negedge clk) begin
		for (int m = 0; m < NM; m++) begin
			if (drv[m].drive === 1'b1) begin
				pulse_cnt[m]++;
				model_pos[m] += drv[m].dir ? 1 : -1;
				if (m == 0 && rec) begin
					if (have_last)
						iv.push_back(cyc - last_cyc);
					last_cyc  = cyc;
					have_last = 1'b1;
				end
			end
		end
	end

	// Home sensor covers everything at or below the sensor point
	always @(posedge clk) begin
		#1;
		for (int m = 0; m < NM; m++)
			zpd[m] = model_pos[m] <= sensor_pt[m];
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic wait_state(input int m, input logic val, input int limit, input string what);
		int n;
		n = 0;
		while (status[m].state !== val && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (status[m].state !== val) begin
			timeouts++;
			$display("Timeout: motor %0d state never went to %0d during %s", m, val, what);
		end
	endtask

	task automatic wait_pulses(input int m, input int cnt, input int limit);
		int n;
		n = 0;
		while (pulse_cnt[m] < cnt && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (pulse_cnt[m] < cnt) begin
			timeouts++;
			$display("Timeout: motor %0d gave only %0d of %0d pulses", m, pulse_cnt[m], cnt);
		end
	endtask

	task automatic set_cmd(input int m, input logic dir, input int spd, input int step);
		@(posedge clk);
		#1;
		cmd[m].dir   = dir;
		cmd[m].speed = ramp_idx_t'(spd);
		cmd[m].step  = step_cnt_t'(step);
		cmd[m].ms    = ms_t'($urandom);
		pulse_cnt[m] = 0;
	endtask

	task automatic pulse_start(input logic [NM-1:0] mask);
		@(posedge clk);
		#1;
		for (int m = 0; m < NM; m++)
			cmd[m].start = mask[m];
		@(posedge clk);
		#1;
		for (int m = 0; m < NM; m++)
			cmd[m].start = 1'b0;
	endtask

	// Start, then expect state one cycle later
	task automatic start_moves(input logic [NM-1:0] mask);
		pulse_start(mask);
		@(negedge clk);
		for (int m = 0; m < NM; m++)
			if (mask[m])
				check($sformatf("status[%0d].state", m), status[m].state, 1'b1);
	endtask

	initial begin
		int       len;
		int       v;
		int       spd;
		int       lvl;
		int       floor_iv;
		int       snap;
		logic     rising;
		int       exp_cnt [NM];

		void'($urandom(46));
		resetn = 1'b0;
		br     = '0;
		for (int m = 0; m < NM; m++) begin
			cmd[m]      = '0;
			cmd[m].xen  = 1'b1;
			stroke[m]   = '0;
			pulse_cnt[m] = 0;
		end
		repeat (8) @(posedge clk);
		#1 resetn = 1'b1;

		// Idle outputs after reset
		@(negedge clk);
		for (int m = 0; m < NM; m++) begin
			check($sformatf("drv[%0d].drive", m), drv[m].drive, 1'b0);
			check($sformatf("status[%0d].state", m), status[m].state, 1'b0);
			check($sformatf("status[%0d].zpsign", m), status[m].zpsign, 1'b0);
			check($sformatf("status[%0d].tpsign", m), status[m].tpsign, 1'b0);
			check($sformatf("drv[%0d].xen", m), drv[m].xen, 1'b1);
			check($sformatf("drv[%0d].xrst", m), drv[m].xrst, 1'b0);
			stroke[m]    = step_cnt_t'(150 + $urandom % 51);
			sensor_pt[m] = 2 + $urandom % 5;
		end

		// Driver enable and reset pins go through one register
		@(posedge clk);
		#1;
		for (int m = 0; m < NM; m++) begin
			cmd[m].xen  = 1'b0;
			cmd[m].xrst = 1'b1;
		end
		@(negedge clk);
		for (int m = 0; m < NM; m++)
			check($sformatf("drv[%0d].xen", m), drv[m].xen, 1'b1);
		@(negedge clk);
		for (int m = 0; m < NM; m++) begin
			check($sformatf("drv[%0d].xen", m), drv[m].xen, 1'b0);
			check($sformatf("drv[%0d].xrst", m), drv[m].xrst, 1'b1);
		end
		@(posedge clk);
		#1;
		for (int m = 0; m < NM; m++) begin
			cmd[m].xen  = 1'b1;
			cmd[m].xrst = 1'b0;
		end

		// Non-increasing ramp, 20 to 40 words
		len = 20 + $urandom % 21;
		v   = 8;
		for (int i = 0; i < len; i++) begin
			if (i > 0 && $urandom % 3 == 0 && v > 1)
				v--;
			tbl.push_back(speed_t'(v));
			@(posedge clk);
			#1;
			br.init  = 1'b1;
			br.wr_en = 1'b1;
			br.data  = speed_t'(v);
		end
		@(posedge clk);
		#1 br = '0;

		// Short upward moves on both axes together
		for (int m = 0; m < NM; m++) begin
			exp_cnt[m] = 10 + $urandom % 31;
			set_cmd(m, 1'b1, $urandom % 41, exp_cnt[m]);
		end
		start_moves('1);
		for (int m = 0; m < NM; m++)
			wait_state(m, 1'b0, 20000, "short move");
		for (int m = 0; m < NM; m++) begin
			check($sformatf("pulses[%0d]", m), pulse_cnt[m], exp_cnt[m]);
			check($sformatf("drv[%0d].dir", m), drv[m].dir, cmd[m].dir);
			check($sformatf("drv[%0d].ms", m), drv[m].ms, cmd[m].ms);
			check($sformatf("status[%0d].tpsign", m), status[m].tpsign, 1'b0);
		end

		// Move past the stroke limit
		for (int m = 0; m < NM; m++) begin
			exp_cnt[m] = stroke[m] - model_pos[m];
			set_cmd(m, 1'b1, $urandom % 41, stroke[m] + 50);
		end
		start_moves('1);
		for (int m = 0; m < NM; m++)
			wait_state(m, 1'b0, 30000, "stroke move");
		@(negedge clk);
		for (int m = 0; m < NM; m++) begin
			check($sformatf("pulses[%0d]", m), pulse_cnt[m], exp_cnt[m]);
			check($sformatf("status[%0d].tpsign", m), status[m].tpsign, 1'b1);
		end

		// Homing down onto the sensor
		for (int m = 0; m < NM; m++) begin
			exp_cnt[m] = model_pos[m] - sensor_pt[m];
			set_cmd(m, 1'b0, $urandom % 41, model_pos[m] + 20);
		end
		start_moves('1);
		for (int m = 0; m < NM; m++)
			wait_state(m, 1'b0, 30000, "homing");
		@(negedge clk);
		for (int m = 0; m < NM; m++) begin
			check($sformatf("pulses[%0d]", m), pulse_cnt[m], exp_cnt[m]);
			check($sformatf("status[%0d].zpsign", m), status[m].zpsign, 1'b1);
			check($sformatf("status[%0d].tpsign", m), status[m].tpsign, 1'b0);
			model_pos[m] = 0;
		end

		// Long move on motor 0, interval profile
		spd = 5 + $urandom % 30;
		set_cmd(0, 1'b1, spd, 100);
		iv.delete();
		have_last = 1'b0;
		rec       = 1'b1;
		start_moves(2'b01);
		wait_state(0, 1'b0, 20000, "long move");
		rec = 1'b0;
		check("pulses[0]", pulse_cnt[0], 100);
		lvl      = spd < len - 1 ? spd : len - 1;
		floor_iv = tbl[lvl] * DIV;
		rising   = 1'b0;
		for (int i = 0; i < iv.size(); i++) begin
			if (iv[i] < floor_iv) begin
				errors++;
				$display("CHECK FAILED at %0t ns: interval[%0d] got %0d expected at least %0d",
					$time, i, iv[i], floor_iv);
			end
			if (i > 0 && iv[i] > iv[i-1])
				rising = 1'b1;
			else if (i > 0 && iv[i] < iv[i-1] && rising) begin
				errors++;
				$display("Step interval %0d shrank again after the ramp began slowing down", i);
			end
		end

		// Stop request on motor 0 mid-move
		set_cmd(0, 1'b0, $urandom % 41, 60);
		start_moves(2'b01);
		wait_pulses(0, 10, 5000);
		@(posedge clk);
		#1 cmd[0].stop = 1'b1;
		@(negedge clk);
		snap = pulse_cnt[0];
		@(posedge clk);
		#1 cmd[0].stop = 1'b0;
		wait_state(0, 1'b0, DIV + 3, "stop");
		repeat (3 * DIV) @(negedge clk);
		check("pulses[0] after stop", pulse_cnt[0], snap);

		// Start while busy is ignored
		set_cmd(1, 1'b1, $urandom % 41, 20);
		start_moves(2'b10);
		wait_pulses(1, 3, 2000);
		@(posedge clk);
		#1;
		cmd[1].dir  = 1'b0;
		cmd[1].step = step_cnt_t'(5);
		pulse_start(2'b10);
		wait_state(1, 1'b0, 20000, "busy start");
		check("pulses[1]", pulse_cnt[1], 20);
		check("drv[1].dir", drv[1].dir, 1'b1);

		// Start while the table is loading is ignored
		set_cmd(0, 1'b1, 3, 10);
		br.init = 1'b1;
		pulse_start(2'b01);
		repeat (4 * DIV) @(negedge clk);
		check("status[0].state", status[0].state, 1'b0);
		check("pulses[0] during load", pulse_cnt[0], 0);
		@(posedge clk);
		#1 br.init = 1'b0;

		repeat (4) @(negedge clk);
		$display("Errors: %0d failed checks, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
